// ==== src/obj_geom_pkg.sv ====
// object table and line table sizes; the table is sized to fill OBJ_AW exactly
package obj_geom_pkg;

    localparam int DATA_W       = 16;                   // every table word
    localparam int OBJ_COUNT    = 64;
    localparam int OBJ_IW       = $clog2(OBJ_COUNT);    // object index
    localparam int OBJ_AW       = OBJ_IW + 2;           // four words per object
    localparam int TBL_WORDS    = OBJ_COUNT * 4;

    // apb word address, one bit wider so that misses can be flagged
    localparam int PADDR_W      = OBJ_AW + 1;

    localparam int LINE_ENTRIES = 32;
    localparam int ENTRY_W      = $clog2(LINE_ENTRIES);
    localparam int LINE_AW      = ENTRY_W + 2;          // entry index and word select
    localparam int BUF_AW       = LINE_AW + 1;          // plus bank bit

    localparam int VPOS_W       = 9;                    // scan line, wraps at 512

endpackage

// ==== src/obj_fmt_pkg.sv ====
// object word order, attribute fields and line entry layout; hflip is passed through only
package obj_fmt_pkg;

    // word order inside one object of the table
    localparam logic [1:0] WORD_ATTR = 2'd0;
    localparam logic [1:0] WORD_CODE = 2'd1;
    localparam logic [1:0] WORD_Y    = 2'd2;
    localparam logic [1:0] WORD_X    = 2'd3;

    // attribute word fields
    localparam int TM_HI     = 15;  // extra tile rows
    localparam int TM_LO     = 12;
    localparam int TN_HI     = 11;  // extra tile columns
    localparam int TN_LO     = 8;
    localparam int VFLIP_BIT = 6;
    localparam int HFLIP_BIT = 5;
    localparam int PAL_HI    = 4;
    localparam int PAL_LO    = 0;

    localparam int TILE_IDX_W = TM_HI - TM_LO + 1;

    localparam int TILE_PX = 16;                // pixels per tile, both ways
    localparam int TILE_SH = $clog2(TILE_PX);

    // line entry words, word 3 is left unwritten
    localparam logic [1:0] ENT_ATTR = 2'd0;
    localparam logic [1:0] ENT_CODE = 2'd1;
    localparam logic [1:0] ENT_X    = 2'd2;

    localparam logic [15:0] ENTRY_FILL = 16'hffff;

endpackage

// ==== src/obj_table_ram.sv ====
// apb object table with word addresses; writes past the table are dropped, reads return zero
`timescale 1ns/1ps

module obj_table_ram (
    input  logic                             clk,
    input  logic                             rst,
    // apb slave
    input  logic [obj_geom_pkg::PADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [obj_geom_pkg::DATA_W-1:0]  pwdata,
    output logic [obj_geom_pkg::DATA_W-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,
    // scanner read port
    input  logic [obj_geom_pkg::OBJ_AW-1:0]  tbl_addr,
    output logic [obj_geom_pkg::DATA_W-1:0]  tbl_data
);
    import obj_geom_pkg::*;

    logic [DATA_W-1:0] mem [TBL_WORDS];
    logic              acc;
    logic              oor;     // address beyond the table
    logic              rd_wait; // first access cycle of a read seen

    assign acc = psel && penable;
    assign oor = paddr >= PADDR_W'(TBL_WORDS);

    assign pready  = acc && (pwrite || rd_wait);
    assign pslverr = pready && oor;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
            prdata  <= '0;
        end else begin
            rd_wait <= acc && !pwrite && !rd_wait;
            if (acc && !pwrite && !rd_wait) begin
                prdata <= oor ? '0 : mem[paddr[OBJ_AW-1:0]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc && pwrite && !oor) begin
            mem[paddr[OBJ_AW-1:0]] <= pwdata;
        end
        tbl_data <= mem[tbl_addr]; // one cycle to the scanner
    end

    // the master must open every access phase with psel held
    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
        else $error("penable high without psel");

endmodule

// ==== src/obj_attr_decode.sv ====
// combinational object decode for one scan line; tile rows come out unflipped
`timescale 1ns/1ps

module obj_attr_decode (
    input  logic [obj_geom_pkg::VPOS_W-1:0]    vrender,
    input  logic [obj_geom_pkg::DATA_W-1:0]    obj_attr,
    input  logic [obj_geom_pkg::DATA_W-1:0]    obj_code,
    input  logic [obj_geom_pkg::DATA_W-1:0]    obj_y,
    input  logic [obj_fmt_pkg::TILE_IDX_W-1:0] tile_n_idx,
    output logic                               inzone,
    output logic [obj_fmt_pkg::TILE_SH-1:0]    vsub,
    output logic [obj_geom_pkg::DATA_W-1:0]    code_mn,
    output logic                               last_col
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [TILE_IDX_W-1:0] tile_m;
    logic [TILE_IDX_W-1:0] tile_n;
    logic [TILE_IDX_W-1:0] row_m;
    logic [VPOS_W-1:0]     dy;      // line offset into the object, mod 512
    logic [VPOS_W-1:0]     height;
    logic                  vflip;

    assign tile_m = obj_attr[TM_HI:TM_LO];
    assign tile_n = obj_attr[TN_HI:TN_LO];
    assign vflip  = obj_attr[VFLIP_BIT];

    assign dy     = vrender - obj_y[VPOS_W-1:0];
    assign height = VPOS_W'((tile_m + 1) * TILE_PX);   // at most 256 lines

    assign inzone = dy < height;

    // only meaningful when inzone, dy is then below 256
    assign row_m = TILE_IDX_W'(dy >> TILE_SH);
    assign vsub  = dy[TILE_SH-1:0] ^ {TILE_SH{vflip}};

    // each nibble wraps on its own
    always_comb begin
        code_mn = obj_code;
        code_mn[7:4] = obj_code[7:4] + row_m;
        code_mn[3:0] = obj_code[3:0] + tile_n_idx;
    end

    assign last_col = tile_n_idx == tile_n;

endmodule

// ==== src/obj_line_scan.sv ====
// line table builder; vrender must stay stable while busy, start is ignored during a scan
`timescale 1ns/1ps

module obj_line_scan (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic [obj_geom_pkg::VPOS_W-1:0]    vrender,
    output logic                               busy,
    output logic                               done,
    // object table
    output logic [obj_geom_pkg::OBJ_AW-1:0]    tbl_addr,
    input  logic [obj_geom_pkg::DATA_W-1:0]    tbl_data,
    // decode
    output logic [obj_geom_pkg::DATA_W-1:0]    obj_attr,
    output logic [obj_geom_pkg::DATA_W-1:0]    obj_code,
    output logic [obj_geom_pkg::DATA_W-1:0]    obj_y,
    output logic [obj_fmt_pkg::TILE_IDX_W-1:0] tile_n_idx,
    input  logic                               inzone,
    input  logic [obj_fmt_pkg::TILE_SH-1:0]    vsub,
    input  logic [obj_geom_pkg::DATA_W-1:0]    code_mn,
    input  logic                               last_col,
    // line buffer
    output logic                               wr_en,
    output logic [obj_geom_pkg::BUF_AW-1:0]    wr_addr,
    output logic [obj_geom_pkg::DATA_W-1:0]    wr_data
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_CHECK, S_WRITE, S_FILL} state_t;

    state_t                state;
    logic [OBJ_IW-1:0]     obj_idx;
    logic [2:0]            fcnt;        // word fetch step, 0 to 4
    logic [1:0]            cap_word;
    logic [1:0]            ww;          // entry word being written
    logic [TILE_IDX_W-1:0] n;
    logic [ENTRY_W:0]      ecnt;        // entries written, up to LINE_ENTRIES
    logic                  prev_valid;
    logic                  repeated;
    logic [DATA_W-1:0]     obj_x;
    logic [DATA_W-1:0]     prev_attr, prev_code, prev_y, prev_x;

    assign tbl_addr   = {obj_idx, fcnt[1:0]};
    assign cap_word   = 2'(fcnt - 3'd1);     // data lags address by one
    assign tile_n_idx = n;
    assign busy       = state != S_IDLE;

    assign repeated = prev_valid && obj_attr == prev_attr && obj_code == prev_code
                      && obj_y == prev_y && obj_x == prev_x;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            obj_idx    <= '0;
            fcnt       <= '0;
            ww         <= ENT_ATTR;
            n          <= '0;
            ecnt       <= '0;
            prev_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    obj_idx    <= OBJ_IW'(OBJ_COUNT - 1);   // highest object first
                    fcnt       <= '0;
                    ecnt       <= '0;
                    prev_valid <= 1'b0;
                    state      <= S_FETCH;
                end
                S_FETCH: begin
                    fcnt <= fcnt + 3'd1;
                    if (fcnt == 3'd4) begin
                        fcnt  <= '0;
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    prev_valid <= 1'b1;
                    n          <= '0;
                    ww         <= ENT_ATTR;
                    if (!repeated && inzone) begin
                        state <= S_WRITE;
                    end else if (obj_idx == '0) begin
                        state <= S_FILL;
                    end else begin
                        obj_idx <= obj_idx - 1'b1;
                        state   <= S_FETCH;
                    end
                end
                S_WRITE: begin
                    ww <= ww + 2'd1;
                    if (ww == ENT_X) begin // entry complete
                        ww   <= ENT_ATTR;
                        ecnt <= ecnt + 1'b1;
                        if (ecnt == (ENTRY_W + 1)'(LINE_ENTRIES - 1)) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end else if (!last_col) begin
                            n <= n + 1'b1;
                        end else if (obj_idx == '0) begin
                            state <= S_FILL;
                        end else begin
                            obj_idx <= obj_idx - 1'b1;
                            state   <= S_FETCH;
                        end
                    end
                end
                S_FILL: begin
                    ww <= ww + 2'd1;
                    if (ww == ENT_X) begin
                        ww   <= ENT_ATTR;
                        ecnt <= ecnt + 1'b1;
                        if (ecnt == (ENTRY_W + 1)'(LINE_ENTRIES - 1)) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // object words, current and previous, shift on each capture
    always_ff @(posedge clk) begin
        if (state == S_FETCH && fcnt != 3'd0) begin
            case (cap_word)
                WORD_ATTR: begin
                    prev_attr <= obj_attr;
                    obj_attr  <= tbl_data;
                end
                WORD_CODE: begin
                    prev_code <= obj_code;
                    obj_code  <= tbl_data;
                end
                WORD_Y: begin
                    prev_y <= obj_y;
                    obj_y  <= tbl_data;
                end
                WORD_X: begin
                    prev_x <= obj_x;
                    obj_x  <= tbl_data;
                end
                default: ;
            endcase
        end
    end

    assign wr_en   = state == S_WRITE || state == S_FILL;
    assign wr_addr = {vrender[0], ecnt[ENTRY_W-1:0], ww};

    always_comb begin
        wr_data = ENTRY_FILL;
        if (state == S_WRITE) begin
            case (ww)
                ENT_ATTR: wr_data = {4'd0, vsub, obj_attr[7], obj_attr[VFLIP_BIT],
                                     obj_attr[HFLIP_BIT], obj_attr[PAL_HI:PAL_LO]};
                ENT_CODE: wr_data = code_mn;
                default:  wr_data = obj_x + DATA_W'(n) * DATA_W'(TILE_PX); // column x
            endcase
        end
    end

    a_ecnt_limit: assert property (@(posedge clk) disable iff (rst)
        ecnt <= (ENTRY_W + 1)'(LINE_ENTRIES))
        else $error("entry count past LINE_ENTRIES");

    a_wr_busy: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> busy && ecnt < (ENTRY_W + 1)'(LINE_ENTRIES))
        else $error("line write outside a scan");

endmodule

// ==== src/obj_line_buf.sv ====
// two line banks; the renderer side always reads the bank not selected by vrender bit 0
`timescale 1ns/1ps

module obj_line_buf (
    input  logic                             clk,
    // scanner write port
    input  logic                             wr_en,
    input  logic [obj_geom_pkg::BUF_AW-1:0]  wr_addr,
    input  logic [obj_geom_pkg::DATA_W-1:0]  wr_data,
    // renderer read port
    input  logic [obj_geom_pkg::VPOS_W-1:0]  vrender,
    input  logic [obj_geom_pkg::LINE_AW-1:0] line_addr,
    output logic [obj_geom_pkg::DATA_W-1:0]  line_data
);
    import obj_geom_pkg::*;

    logic [DATA_W-1:0] mem [2**BUF_AW];
    logic              rd_bank;

    assign rd_bank = ~vrender[0];   // previous line

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        line_data <= mem[{rd_bank, line_addr}];
    end

    // scanner bank selection must never collide with the renderer
    a_bank_split: assert property (@(posedge clk) wr_en |-> wr_addr[BUF_AW-1] != rd_bank)
        else $error("line write into the bank being read");

endmodule

// ==== src/obj_line_top.sv ====
// sprite line table top; all paths pass through without added latency
`timescale 1ns/1ps

module obj_line_top (
    input  logic                             clk,
    input  logic                             rst,
    // apb cpu port
    input  logic [obj_geom_pkg::PADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [obj_geom_pkg::DATA_W-1:0]  pwdata,
    output logic [obj_geom_pkg::DATA_W-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,
    // scan control
    input  logic                             start,
    input  logic [obj_geom_pkg::VPOS_W-1:0]  vrender,
    output logic                             busy,
    output logic                             done,
    // renderer
    input  logic [obj_geom_pkg::LINE_AW-1:0] line_addr,
    output logic [obj_geom_pkg::DATA_W-1:0]  line_data
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [OBJ_AW-1:0]     tbl_addr;
    logic [DATA_W-1:0]     tbl_data;
    logic [DATA_W-1:0]     obj_attr, obj_code, obj_y;
    logic [TILE_IDX_W-1:0] tile_n_idx;
    logic                  inzone;
    logic [TILE_SH-1:0]    vsub;
    logic [DATA_W-1:0]     code_mn;
    logic                  last_col;
    logic                  wr_en;
    logic [BUF_AW-1:0]     wr_addr;
    logic [DATA_W-1:0]     wr_data;

    obj_table_ram i_obj_table_ram (
        .clk, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .tbl_addr, .tbl_data
    );

    obj_attr_decode i_obj_attr_decode (
        .vrender, .obj_attr, .obj_code, .obj_y, .tile_n_idx,
        .inzone, .vsub, .code_mn, .last_col
    );

    obj_line_scan i_obj_line_scan (
        .clk, .rst, .start, .vrender, .busy, .done,
        .tbl_addr, .tbl_data,
        .obj_attr, .obj_code, .obj_y, .tile_n_idx,
        .inzone, .vsub, .code_mn, .last_col,
        .wr_en, .wr_addr, .wr_data
    );

    obj_line_buf i_obj_line_buf (
        .clk, .wr_en, .wr_addr, .wr_data,
        .vrender, .line_addr, .line_data
    );

endmodule

// ==== tests/obj_line_checker.sv ====
// reference line model; assumes no table writes during a scan, entry word 3 is not compared
`timescale 1ns/1ps

module obj_line_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [obj_geom_pkg::PADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [obj_geom_pkg::DATA_W-1:0]  pwdata,
    input  logic                             pready,
    input  logic                             start,
    input  logic [obj_geom_pkg::VPOS_W-1:0]  vrender,
    input  logic                             busy,
    input  logic                             done,
    input  logic [obj_geom_pkg::LINE_AW-1:0] line_addr,
    input  logic [obj_geom_pkg::DATA_W-1:0]  line_data,
    output int                               errors,
    output int                               done_count
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [DATA_W-1:0]  tbl [TBL_WORDS];            // mirror of apb writes
    logic [DATA_W-1:0]  exp_line [2][4*LINE_ENTRIES];
    logic [1:0]         bank_ok;                    // bank holds a finished line
    logic               build_bank;
    logic               rd_valid;
    logic               rd_bank;
    logic [LINE_AW-1:0] rd_addr;
    int                 err_cnt = 0;
    int                 dn_cnt = 0;

    assign errors     = err_cnt;
    assign done_count = dn_cnt;

    task automatic build_line(input logic [VPOS_W-1:0] v, input logic b);
        int                o;
        int                k;
        int                e;
        logic [DATA_W-1:0] a, c, y, x;
        logic [VPOS_W-1:0] dy;
        logic [3:0]        sub;
        e = 0;
        for (o = OBJ_COUNT - 1; o >= 0; o--) begin   // top object first
            a = tbl[4 * o];
            c = tbl[4 * o + 1];
            y = tbl[4 * o + 2];
            x = tbl[4 * o + 3];
            dy  = v - y[VPOS_W-1:0];                 // wraps at 512
            sub = dy[3:0] ^ {4{a[VFLIP_BIT]}};
            if ((o == OBJ_COUNT - 1 || a != tbl[4 * o + 4] || c != tbl[4 * o + 5]
                    || y != tbl[4 * o + 6] || x != tbl[4 * o + 7])
                    && int'(dy) < TILE_PX * (int'(a[TM_HI:TM_LO]) + 1)) begin
                for (k = 0; k <= int'(a[TN_HI:TN_LO]) && e < LINE_ENTRIES; k++) begin
                    exp_line[b][4 * e]     = {4'h0, sub, a[7:0]};
                    exp_line[b][4 * e + 1] = {c[15:8], c[7:4] + dy[7:4], c[3:0] + 4'(k)};
                    exp_line[b][4 * e + 2] = x + 16'(TILE_PX * k);
                    e++;
                end
            end
        end
        while (e < LINE_ENTRIES) begin
            exp_line[b][4 * e]     = ENTRY_FILL;
            exp_line[b][4 * e + 1] = ENTRY_FILL;
            exp_line[b][4 * e + 2] = ENTRY_FILL;
            e++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            bank_ok  = 2'b00;
            rd_valid <= 1'b0;
        end else begin
            // line_data now holds the word addressed one cycle ago
            if (rd_valid && rd_addr[1:0] != 2'd3 && line_data !== exp_line[rd_bank][rd_addr]) begin
                err_cnt++;
                $display("error line_data at %h: got %h, expected %h",
                         rd_addr, line_data, exp_line[rd_bank][rd_addr]);
            end
            if (psel && penable && pwrite && pready && paddr < PADDR_W'(TBL_WORDS)) begin
                tbl[paddr[OBJ_AW-1:0]] = pwdata;
            end
            if (done) begin
                dn_cnt++;
                bank_ok[build_bank] = 1'b1;
                if (busy) begin
                    err_cnt++;
                    $display("busy still high in the cycle where done pulsed");
                end
            end
            if (start && !busy) begin
                build_line(vrender, vrender[0]);
                build_bank          <= vrender[0];
                bank_ok[vrender[0]] = 1'b0;
            end
            // a bank finished in this cycle is already readable
            rd_valid <= bank_ok[~vrender[0]];
            rd_bank  <= ~vrender[0];
            rd_addr  <= line_addr;
        end
    end

endmodule

// ==== tests/obj_line_tb.sv ====
// sprite line test; the whole object table is written before the first scan and never during one
`timescale 1ns/1ps

module obj_line_tb;
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    localparam int N_OBJ_ROWS  = 8;
    localparam int N_SCAN_ROWS = 12;
    localparam int N_RAND_OBJ  = 24;
    localparam int LINE_READ   = 4 * LINE_ENTRIES;
    localparam int SCAN_MAX    = 1 + OBJ_COUNT * 6 + LINE_ENTRIES * 3;  // fetch and check, then writes
    localparam int MAX_CYCLES  = N_SCAN_ROWS * (SCAN_MAX + LINE_READ + 4) + 6 * TBL_WORDS + 20;

    logic               clk = 1'b0;
    logic               rst, psel, penable, pwrite, start;
    logic [PADDR_W-1:0] paddr;
    logic [DATA_W-1:0]  pwdata, prdata, line_data;
    logic               pready, pslverr, busy, done;
    logic [VPOS_W-1:0]  vrender;
    logic [LINE_AW-1:0] line_addr;
    int                 tb_errors = 0;
    int                 chk_errors, done_count;
    int                 cycles = 0;
    int                 scans = 0;
    int                 seed = 32'h9128938b;

    // index, attr, code, y, x
    logic [15:0] obj_rows [N_OBJ_ROWS][5] = '{
        '{16'd60, 16'h0005, 16'h1230, 16'h0020, 16'h0040},  // single tile
        '{16'd50, 16'h1243, 16'h2a5e, 16'h0060, 16'h0ff0},  // 3 wide, 2 high, vflip
        '{16'd40, 16'h0001, 16'h0500, 16'h00a0, 16'h0080},  // adjacent copies
        '{16'd39, 16'h0001, 16'h0500, 16'h00a0, 16'h0080},
        '{16'd38, 16'h0182, 16'h0600, 16'h00a8, 16'h0090},
        '{16'd30, 16'h0f07, 16'h0700, 16'h00e0, 16'h0000},  // 16 tiles each, overflows
        '{16'd29, 16'h0f08, 16'h0800, 16'h00e0, 16'h0100},
        '{16'd28, 16'h0f09, 16'h0900, 16'h00e0, 16'h0200}
    };

    // scan line and entry count, -1 where the random set decides
    int scan_rows [N_SCAN_ROWS][2] = '{
        '{'h025, 1}, '{'h030, 0}, '{'h063, 3}, '{'h06c, 3}, '{'h071, 3}, '{'h0a9, 3},
        '{'h0e4, 32}, '{'h150, -1}, '{'h151, -1}, '{'h152, -1}, '{'h153, -1}, '{'h154, -1}
    };

    obj_line_top i_obj_line_top (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .start, .vrender, .busy, .done, .line_addr, .line_data
    );

    obj_line_checker i_obj_line_checker (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .pready,
        .start, .vrender, .busy, .done, .line_addr, .line_data,
        .errors(chk_errors), .done_count(done_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            tb_errors++;
            $display("error %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic apb_write(input logic [PADDR_W-1:0] a, input logic [15:0] d, output logic err);
        paddr = a;
        pwdata = d;
        pwrite = 1'b1;
        psel = 1'b1;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        check_value("pready", 16'(pready), 16'h1);  // no wait state on writes
        err = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [PADDR_W-1:0] a, output logic [15:0] d, output logic err);
        paddr = a;
        pwrite = 1'b0;
        psel = 1'b1;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        check_value("pready", 16'(pready), 16'h0);  // the one wait state
        @(negedge clk);
        check_value("pready", 16'(pready), 16'h1);
        d = prdata;
        err = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_object(input int idx, input logic [15:0] a, c, y, x);
        logic err;
        apb_write(PADDR_W'(4 * idx), a, err);
        check_value("pslverr", 16'(err), 16'h0);
        apb_write(PADDR_W'(4 * idx + 1), c, err);
        apb_write(PADDR_W'(4 * idx + 2), y, err);
        apb_write(PADDR_W'(4 * idx + 3), x, err);
    endtask

    task automatic read_line(output int cnt);
        int a;
        cnt = 0;
        for (a = 0; a < LINE_READ; a++) begin
            line_addr = LINE_AW'(a);
            @(posedge clk);
            #1;
            if (a % 4 == 0 && line_data != ENTRY_FILL) cnt++;   // real entries have top nibble 0
        end
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        logic [15:0] w [4];
        logic [15:0] rd;
        logic        err;
        int          i;
        int          k;
        int          cnt;
        rst = 1'b1;
        start = 1'b0;
        vrender = '0;
        line_addr = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        check_value("busy", 16'(busy), 16'h0);
        check_value("done", 16'(done), 16'h0);
        check_value("prdata", prdata, 16'h0);

        for (i = 0; i < OBJ_COUNT; i++) begin
            write_object(i, 16'h0000, 16'(i), 16'h01f0, 16'h0000);  // visible only near line 0x1f0
        end
        for (i = N_RAND_OBJ - 1; i >= 0; i--) begin
            // kept words repeat the object above now and then
            if (i == N_RAND_OBJ - 1 || ($random(seed) & 7) != 0) begin
                w[0] = {2'b00, 2'($random(seed)), 2'b00, 2'($random(seed)), 8'($random(seed))};
                w[1] = 16'($random(seed));
                w[2] = 16'h0140 + 16'($random(seed) & 31);
                w[3] = 16'($random(seed));
            end
            write_object(i, w[0], w[1], w[2], w[3]);
        end
        for (i = 0; i < N_OBJ_ROWS; i++) begin
            write_object(int'(obj_rows[i][0]), obj_rows[i][1], obj_rows[i][2],
                         obj_rows[i][3], obj_rows[i][4]);
        end
        for (i = 0; i < N_OBJ_ROWS; i++) begin
            for (k = 0; k < 4; k++) begin
                apb_read(PADDR_W'(4 * obj_rows[i][0] + k), rd, err);
                check_value("prdata", rd, obj_rows[i][k + 1]);
                check_value("pslverr", 16'(err), 16'h0);
            end
        end
        apb_read(PADDR_W'(TBL_WORDS), rd, err);
        check_value("pslverr", 16'(err), 16'h1);
        apb_write(PADDR_W'(2 * TBL_WORDS - 1), 16'hdead, err);
        check_value("pslverr", 16'(err), 16'h1);

        for (i = 0; i < N_SCAN_ROWS; i++) begin
            vrender = VPOS_W'(scan_rows[i][0]);
            start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            read_line(cnt);         // previous line while this one is built
            wait_done();
            scans++;
            vrender = vrender + VPOS_W'(1);
            read_line(cnt);
            if (scan_rows[i][1] >= 0) check_value("entry count", 16'(cnt), 16'(scan_rows[i][1]));
            check_value("done pulses", 16'(done_count), 16'(scans));
        end

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/obj_geom_pkg.sv
src/obj_fmt_pkg.sv
src/obj_table_ram.sv
src/obj_attr_decode.sv
src/obj_line_scan.sv
src/obj_line_buf.sv
src/obj_line_top.sv
tests/obj_line_checker.sv
tests/obj_line_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the sprite line testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -sv \
    --top-module obj_line_tb -f flist.f -Mdir obj_dir -o obj_line_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/obj_line_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
